//--- src/fetch_pkg.sv
package fetch_pkg;

  // datapath and predictor sizes
  localparam int xlen        = 32;
  localparam int his_len     = 8;
  localparam int pht_entries = 256;
  localparam int btb_entries = 16;

  // derived index and tag widths, word aligned fetch addresses
  localparam int pht_idx_len = $clog2(pht_entries);    // pc bits 9..2
  localparam int btb_idx_len = $clog2(btb_entries);    // pc bits 5..2
  localparam int btb_tag_len = xlen - btb_idx_len - 2; // pc bits 31..6

  // trap bus layout
  localparam int trap_len                  = 16;
  localparam int trap_inst_addr_misaligned = 0;
  localparam int trap_inst_access_fault    = 1;
  localparam int trap_inst_page_fault      = 12;

  typedef enum logic [1:0] {
    jt_none   = 2'b00,
    jt_jal    = 2'b01,
    jt_jalr   = 2'b10,
    jt_branch = 2'b11
  } jump_type_t;

  // training info from execute
  typedef struct packed {
    logic               valid;
    logic               taken;     // resolved direction
    logic [xlen-1:0]    pc;
    logic [xlen-1:0]    target;    // resolved target
    jump_type_t         jump_type;
    logic [his_len-1:0] history;   // history seen at prediction time
  } bpu_update_t;

  typedef struct packed {
    logic            hit;
    logic [xlen-1:0] target;
    jump_type_t      jump_type;
  } btb_lookup_t;

  // toward pc register and execute
  typedef struct packed {
    logic               redirect;
    logic [xlen-1:0]    target;
    logic               pred_taken;
    logic [xlen-1:0]    pc_tag;
    logic [his_len-1:0] history;
  } fetch_pred_t;

  typedef logic [trap_len-1:0] trap_bus_t;

endpackage

//--- src/gshare_predictor.sv
`timescale 1ns/100ps

module gshare_predictor (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic [fetch_pkg::xlen-1:0]       pc_i,
  input  fetch_pkg::bpu_update_t           upd_i,
  output logic                             taken_o,
  output logic [fetch_pkg::his_len-1:0]    history_o
);

  // 2-bit saturating counters, 0/1 not taken, 2/3 taken
  logic [1:0] pht_q [fetch_pkg::pht_entries];

  // global history, moves only on resolved branches
  logic [fetch_pkg::his_len-1:0] history_q;

  logic [fetch_pkg::pht_idx_len-1:0] lookup_idx;
  logic [fetch_pkg::pht_idx_len-1:0] upd_idx;
  logic                              upd_branch;
  logic [1:0]                        upd_cnt;

  assign lookup_idx = pc_i[2 +: fetch_pkg::pht_idx_len] ^ history_q;

  // train with the history the branch was predicted under
  assign upd_idx    = upd_i.pc[2 +: fetch_pkg::pht_idx_len] ^ upd_i.history;
  assign upd_branch = upd_i.valid && (upd_i.jump_type == fetch_pkg::jt_branch);
  assign upd_cnt    = pht_q[upd_idx];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < fetch_pkg::pht_entries; i++) begin
        pht_q[i] <= 2'd1; // weakly not taken
      end
      history_q <= '0;
    end else if (upd_branch) begin
      if (upd_i.taken) begin
        if (upd_cnt != 2'd3) begin
          pht_q[upd_idx] <= upd_cnt + 2'd1;
        end
      end else begin
        if (upd_cnt != 2'd0) begin
          pht_q[upd_idx] <= upd_cnt - 2'd1;
        end
      end
      history_q <= {history_q[fetch_pkg::his_len-2:0], upd_i.taken};
    end
  end

  assign taken_o   = pht_q[lookup_idx][1]; // msb set means 2 or 3
  assign history_o = history_q;

endmodule

//--- src/branch_target_buffer.sv
`timescale 1ns/100ps

module branch_target_buffer (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic [fetch_pkg::xlen-1:0] pc_i,
  input  fetch_pkg::bpu_update_t     upd_i,
  output fetch_pkg::btb_lookup_t     lookup_o
);

  // direct mapped, one entry per index
  logic                                valid_q  [fetch_pkg::btb_entries];
  logic [fetch_pkg::btb_tag_len-1:0]   tag_q    [fetch_pkg::btb_entries];
  logic [fetch_pkg::xlen-1:0]          target_q [fetch_pkg::btb_entries];
  fetch_pkg::jump_type_t               jt_q     [fetch_pkg::btb_entries];

  logic [fetch_pkg::btb_idx_len-1:0]   rd_idx;
  logic [fetch_pkg::btb_tag_len-1:0]   rd_tag;
  logic [fetch_pkg::btb_idx_len-1:0]   wr_idx;
  logic [fetch_pkg::btb_tag_len-1:0]   wr_tag;
  logic                                wr_en;

  assign rd_idx = pc_i[2 +: fetch_pkg::btb_idx_len];
  assign rd_tag = pc_i[fetch_pkg::xlen-1 -: fetch_pkg::btb_tag_len];

  assign wr_idx = upd_i.pc[2 +: fetch_pkg::btb_idx_len];
  assign wr_tag = upd_i.pc[fetch_pkg::xlen-1 -: fetch_pkg::btb_tag_len];

  // only taken jumps allocate, older entry is simply replaced
  assign wr_en  = upd_i.valid && upd_i.taken && (upd_i.jump_type != fetch_pkg::jt_none);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < fetch_pkg::btb_entries; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= upd_i.target;
      jt_q[wr_idx]     <= upd_i.jump_type;
    end
  end

  always_comb begin
    lookup_o.hit       = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    lookup_o.target    = target_q[rd_idx];
    lookup_o.jump_type = jt_q[rd_idx];
  end

endmodule

//--- src/fetch_decide.sv
`timescale 1ns/100ps

module fetch_decide (
  input  logic [fetch_pkg::xlen-1:0]    pc_i,
  input  logic [fetch_pkg::xlen-1:0]    rdata_i,
  input  logic                          rdata_valid_i,
  input  logic                          rdata_err_i,
  input  logic                          mem_stall_i,
  input  logic                          flush_i,
  input  logic                          dir_taken_i,
  input  logic [fetch_pkg::his_len-1:0] history_i,
  input  fetch_pkg::btb_lookup_t        lookup_i,
  output fetch_pkg::fetch_pred_t        pred_o,
  output logic                          stall_req_o,
  output fetch_pkg::trap_bus_t          trap_o,
  output logic [fetch_pkg::xlen-1:0]    inst_addr_o,
  output logic [fetch_pkg::xlen-1:0]    inst_data_o
);

  logic jump_ok;
  logic redirect;
  logic misaligned;

  // unconditional jumps always go, branches ask the direction predictor
  always_comb begin
    case (lookup_i.jump_type)
      fetch_pkg::jt_jal,
      fetch_pkg::jt_jalr:   jump_ok = 1'b1;
      fetch_pkg::jt_branch: jump_ok = dir_taken_i;
      default:              jump_ok = 1'b0;
    endcase
  end

  assign redirect = lookup_i.hit && jump_ok && !flush_i;

  always_comb begin
    pred_o.redirect   = redirect;
    pred_o.target     = lookup_i.target;
    pred_o.pred_taken = redirect;
    pred_o.pc_tag     = pc_i;      // lets execute match the prediction
    pred_o.history    = history_i;
  end

  // memory stage stall already holds the pipe
  assign stall_req_o = !rdata_valid_i && !mem_stall_i;

  assign misaligned = (pc_i[1:0] != 2'b00);

  always_comb begin
    for (int i = 0; i < fetch_pkg::trap_len; i++) begin
      if (i == fetch_pkg::trap_inst_addr_misaligned) begin
        trap_o[i] = misaligned;
      end else if (i == fetch_pkg::trap_inst_access_fault) begin
        trap_o[i] = rdata_err_i;
      end else if (i == fetch_pkg::trap_inst_page_fault) begin
        trap_o[i] = 1'b0; // no paging in this core
      end else begin
        trap_o[i] = 1'b0;
      end
    end
  end

  // straight through to decode
  assign inst_addr_o = pc_i;
  assign inst_data_o = rdata_i;

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic [fetch_pkg::xlen-1:0] inst_addr_i,   // from pc register
  input  logic [fetch_pkg::xlen-1:0] rdata_i,
  input  logic                       rdata_valid_i,
  input  logic                       rdata_err_i,
  input  logic                       mem_stall_i,
  input  logic                       flush_i,
  input  fetch_pkg::bpu_update_t     upd_i,         // from execute
  output fetch_pkg::fetch_pred_t     pred_o,
  output logic                       stall_req_o,
  output fetch_pkg::trap_bus_t       trap_o,
  output logic [fetch_pkg::xlen-1:0] inst_addr_o,
  output logic [fetch_pkg::xlen-1:0] inst_data_o
);

  logic                          dir_taken;
  logic [fetch_pkg::his_len-1:0] history;
  fetch_pkg::btb_lookup_t        btb_lookup;

  // both tables look up the fetch address side by side
  gshare_predictor u_gshare (
    .clk       (clk),
    .rst_i     (rst_i),
    .pc_i      (inst_addr_i),
    .upd_i     (upd_i),
    .taken_o   (dir_taken),
    .history_o (history)
  );

  branch_target_buffer u_btb (
    .clk      (clk),
    .rst_i    (rst_i),
    .pc_i     (inst_addr_i),
    .upd_i    (upd_i),
    .lookup_o (btb_lookup)
  );

  fetch_decide u_decide (
    .pc_i          (inst_addr_i),
    .rdata_i       (rdata_i),
    .rdata_valid_i (rdata_valid_i),
    .rdata_err_i   (rdata_err_i),
    .mem_stall_i   (mem_stall_i),
    .flush_i       (flush_i),
    .dir_taken_i   (dir_taken),
    .history_i     (history),
    .lookup_i      (btb_lookup),
    .pred_o        (pred_o),
    .stall_req_o   (stall_req_o),
    .trap_o        (trap_o),
    .inst_addr_o   (inst_addr_o),
    .inst_data_o   (inst_data_o)
  );

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int half_period  = 20; // 40 ns clock
  localparam int reset_cycles = 2;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0; // released away from the rising edge
  end

endmodule

//--- bench/fetch_unit_tb.sv
`timescale 1ns/100ps

module fetch_unit_tb;

  localparam int half_period     = 20;
  localparam int clk_period      = 40;
  localparam int reset_cycles    = 2;
  localparam int directed_cycles = 49;
  localparam int random_cycles   = 400;
  localparam int total_cycles    = reset_cycles + directed_cycles + random_cycles + 1;

  localparam logic [31:0] warm_pc    = 32'h0000_0048; // only used to push ones into history
  localparam logic [31:0] br_pc      = 32'h0000_0104;
  localparam logic [31:0] br_target  = 32'h0000_0600;
  localparam logic [31:0] jal_pc     = 32'h0000_2010;
  localparam logic [31:0] jal_target = 32'h0000_8000;
  localparam logic [31:0] alias_pc   = 32'h0000_3010; // same btb index as jal_pc but another tag

  logic                                 clk;
  logic                                 rst;
  logic [fetch_pkg::xlen-1:0]           inst_addr;
  logic [fetch_pkg::xlen-1:0]           rdata;
  logic                                 rdata_valid;
  logic                                 rdata_err;
  logic                                 mem_stall;
  logic                                 flush;
  fetch_pkg::bpu_update_t               upd;
  fetch_pkg::fetch_pred_t               pred;
  logic                                 stall_req;
  fetch_pkg::trap_bus_t                 trap;
  logic [fetch_pkg::xlen-1:0]           inst_addr_out;
  logic [fetch_pkg::xlen-1:0]           inst_data_out;

  // reference state
  logic [1:0]            ref_pht [256];
  logic [7:0]            ref_hist;
  logic                  ref_btb_valid [16];
  logic [25:0]           ref_btb_tag [16];
  logic [31:0]           ref_btb_target [16];
  fetch_pkg::jump_type_t ref_btb_jt [16];

  tb_clock_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  fetch_unit uut (
    .clk           (clk),
    .rst_i         (rst),
    .inst_addr_i   (inst_addr),
    .rdata_i       (rdata),
    .rdata_valid_i (rdata_valid),
    .rdata_err_i   (rdata_err),
    .mem_stall_i   (mem_stall),
    .flush_i       (flush),
    .upd_i         (upd),
    .pred_o        (pred),
    .stall_req_o   (stall_req),
    .trap_o        (trap),
    .inst_addr_o   (inst_addr_out),
    .inst_data_o   (inst_data_out)
  );

  function automatic void reset_model();
    for (int i = 0; i < 256; i++) begin
      ref_pht[i] = 2'd1;
    end
    for (int i = 0; i < 16; i++) begin
      ref_btb_valid[i]  = 1'b0;
      ref_btb_tag[i]    = '0;
      ref_btb_target[i] = '0;
      ref_btb_jt[i]     = fetch_pkg::jt_none;
    end
    ref_hist = '0;
  endfunction

  function automatic void train_model(input fetch_pkg::bpu_update_t u);
    logic [7:0] ci;
    logic [3:0] bi;
    ci = u.pc[9:2] ^ u.history; // counter seen at prediction time
    bi = u.pc[5:2];
    if (u.jump_type == fetch_pkg::jt_branch) begin
      if (u.taken && ref_pht[ci] != 2'd3) begin
        ref_pht[ci] = ref_pht[ci] + 2'd1;
      end else if (!u.taken && ref_pht[ci] != 2'd0) begin
        ref_pht[ci] = ref_pht[ci] - 2'd1;
      end
      ref_hist = {ref_hist[6:0], u.taken};
    end
    if (u.taken && u.jump_type != fetch_pkg::jt_none) begin
      ref_btb_valid[bi]  = 1'b1;
      ref_btb_tag[bi]    = u.pc[31:6];
      ref_btb_target[bi] = u.target;
      ref_btb_jt[bi]     = u.jump_type;
    end
  endfunction

  function automatic fetch_pkg::fetch_pred_t expected_pred(input logic [31:0] pc,
                                                           input logic flush_in);
    fetch_pkg::fetch_pred_t p;
    logic [3:0] bi;
    logic       hit;
    logic       dir;
    logic       go;
    bi  = pc[5:2];
    hit = ref_btb_valid[bi] && (ref_btb_tag[bi] == pc[31:6]);
    dir = (ref_pht[pc[9:2] ^ ref_hist] >= 2'd2);
    go  = (ref_btb_jt[bi] == fetch_pkg::jt_jal) || (ref_btb_jt[bi] == fetch_pkg::jt_jalr) ||
          (ref_btb_jt[bi] == fetch_pkg::jt_branch && dir);
    p.redirect   = hit && go && !flush_in;
    p.target     = ref_btb_target[bi];
    p.pred_taken = p.redirect;
    p.pc_tag     = pc;
    p.history    = ref_hist;
    return p;
  endfunction

  function automatic fetch_pkg::trap_bus_t expected_trap(input logic [31:0] pc, input logic err);
    fetch_pkg::trap_bus_t t;
    t    = '0;
    t[0] = (pc[1:0] != 2'b00);
    t[1] = err;
    return t;
  endfunction

  function automatic logic expected_stall(input logic valid, input logic mstall);
    return !valid && !mstall;
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_pred(input fetch_pkg::fetch_pred_t got, input fetch_pkg::fetch_pred_t exp,
                            input logic target_known);
    if (got.redirect !== exp.redirect || got.pred_taken !== exp.pred_taken ||
        got.pc_tag !== exp.pc_tag || got.history !== exp.history ||
        (target_known && got.target !== exp.target)) begin
      report_error($sformatf("pred at pc %h: redirect %b/%b target %h/%h history %h/%h",
                             exp.pc_tag, got.redirect, exp.redirect, got.target, exp.target,
                             got.history, exp.history));
    end
  endtask

  task automatic check_trap(input fetch_pkg::trap_bus_t got, input fetch_pkg::trap_bus_t exp);
    if (got !== exp) begin
      report_error($sformatf("trap bus %h, expected %h", got, exp));
    end
  endtask

  task automatic check_stall(input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("stall request %b, expected %b", got, exp));
    end
  endtask

  task automatic check_word(input logic [fetch_pkg::xlen-1:0] got,
                            input logic [fetch_pkg::xlen-1:0] exp, input string what);
    if (got !== exp) begin
      report_error($sformatf("%s %h, expected %h", what, got, exp));
    end
  endtask

  // samples just before the next rising edge
  task automatic expect_redirect(input logic exp, input string what);
    #(half_period - 2);
    if (pred.redirect !== exp) begin
      report_error($sformatf("%s: redirect %b, expected %b", what, pred.redirect, exp));
    end
  endtask

  task automatic set_inputs(input logic [31:0] addr, input logic [31:0] data, input logic valid,
                            input logic err, input logic mstall, input logic flush_in,
                            input fetch_pkg::bpu_update_t u);
    inst_addr   = addr;
    rdata       = data;
    rdata_valid = valid;
    rdata_err   = err;
    mem_stall   = mstall;
    flush       = flush_in;
    upd         = u;
  endtask

  task automatic drive_all(input logic [31:0] addr, input logic [31:0] data, input logic valid,
                           input logic err, input logic mstall, input logic flush_in,
                           input fetch_pkg::bpu_update_t u);
    @(negedge clk);
    set_inputs(addr, data, valid, err, mstall, flush_in, u);
  endtask

  task automatic drive(input logic [31:0] addr, input logic flush_in,
                       input fetch_pkg::bpu_update_t u);
    drive_all(addr, $urandom, 1'b1, 1'b0, 1'b0, flush_in, u);
  endtask

  function automatic fetch_pkg::bpu_update_t make_upd(input logic [31:0] pc,
      input logic [31:0] target, input fetch_pkg::jump_type_t jt, input logic taken,
      input logic [7:0] hist);
    fetch_pkg::bpu_update_t u;
    u.valid     = 1'b1;
    u.taken     = taken;
    u.pc        = pc;
    u.target    = target;
    u.jump_type = jt;
    u.history   = hist;
    return u;
  endfunction

  // eight fetch addresses where pairs share an index but not a tag
  function automatic logic [31:0] pool_addr(input logic [2:0] k);
    return {21'h00_0001, k[2], 6'b000000, k[1:0], 2'b00};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      reset_model();
    end else if (upd.valid) begin
      train_model(upd);
    end
  end

  always @(negedge clk) begin
    fetch_pkg::fetch_pred_t exp_pred;
    #(half_period - 1);
    if (!rst) begin
      exp_pred = expected_pred(inst_addr, flush);
      check_pred(pred, exp_pred, ref_btb_valid[inst_addr[5:2]]);
      check_trap(trap, expected_trap(inst_addr, rdata_err));
      check_stall(stall_req, expected_stall(rdata_valid, mem_stall));
      check_word(inst_addr_out, inst_addr, "instruction address");
      check_word(inst_data_out, rdata, "instruction data");
    end
  end

  initial begin
    #(2 * total_cycles * clk_period);
    $display("timeout: the run did not finish within %0d cycles", 2 * total_cycles);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    fetch_pkg::bpu_update_t u;
    logic [31:0]            r;
    logic [31:0]            addr;
    void'($urandom(59563));
    set_inputs('0, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0);
    wait (!rst);

    // cold predictor over every valid and mem stall level
    for (int a = 0; a < 4; a++) begin
      for (int c = 0; c < 4; c++) begin
        drive_all(32'h0000_0104 + 32'(a) * 32'h0000_0410, $urandom, c[0], 1'b0, c[1], 1'b0,
                  '0);
        expect_redirect(1'b0, "after reset");
      end
    end

    // conditional branch trained under an all ones history
    drive(br_pc, 1'b0, '0);
    expect_redirect(1'b0, "untrained branch");
    repeat (8) begin
      drive(br_pc, 1'b0, make_upd(warm_pc, 32'h0000_0700, fetch_pkg::jt_branch, 1'b1, 8'h00));
    end
    drive(br_pc, 1'b0, make_upd(br_pc, br_target, fetch_pkg::jt_branch, 1'b1, 8'hff));
    expect_redirect(1'b0, "branch before its first update lands");
    drive(br_pc, 1'b0, make_upd(br_pc, br_target, fetch_pkg::jt_branch, 1'b1, 8'hff));
    expect_redirect(1'b1, "branch with counter at 2");
    repeat (3) begin
      drive(br_pc, 1'b0, make_upd(br_pc, br_target, fetch_pkg::jt_branch, 1'b0, 8'hff));
    end
    repeat (8) begin
      drive(br_pc, 1'b0, make_upd(warm_pc, 32'h0000_0700, fetch_pkg::jt_branch, 1'b1, 8'h00));
    end
    drive(br_pc, 1'b0, '0);
    expect_redirect(1'b0, "branch after not taken training");

    // unconditional jump and a tag alias
    drive(jal_pc, 1'b0, make_upd(jal_pc, jal_target, fetch_pkg::jt_jal, 1'b1, ref_hist));
    expect_redirect(1'b0, "jal before its update lands");
    drive(jal_pc, 1'b0, '0);
    expect_redirect(1'b1, "jal after one update");
    drive(alias_pc, 1'b0, '0);
    expect_redirect(1'b0, "alias with other tag");

    drive(jal_pc, 1'b1, '0);
    expect_redirect(1'b0, "jal under flush");
    drive(jal_pc, 1'b0, '0);
    expect_redirect(1'b1, "jal after flush drops");

    // misaligned fetches and access faults
    for (int i = 1; i < 4; i++) begin
      drive_all(jal_pc + 32'(i), $urandom, 1'b1, 1'b0, 1'b0, 1'b0, '0);
    end
    drive_all(br_pc, $urandom, 1'b1, 1'b1, 1'b0, 1'b0, '0);
    drive_all(br_pc + 32'd2, $urandom, 1'b0, 1'b1, 1'b0, 1'b0, '0);

    repeat (random_cycles) begin
      @(negedge clk);
      r    = $urandom;
      addr = pool_addr(r[2:0]);
      if (r[7:4] == 4'd0) begin
        addr = addr + 32'd2; // occasional misaligned fetch
      end
      u.valid     = r[8];
      u.taken     = r[9];
      u.jump_type = fetch_pkg::jump_type_t'(r[11:10]);
      u.pc        = pool_addr(r[14:12]);
      u.target    = $urandom & 32'hffff_fffc;
      u.history   = (r[16:15] == 2'd0) ? 8'($urandom) : ref_hist;
      set_inputs(addr, $urandom, r[19:17] != 3'd0, r[23:20] == 4'd0, r[25:24] == 2'd0,
                 r[28:26] == 3'd0, u);
    end

    @(negedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

//--- filelist.f
src/fetch_pkg.sv
src/gshare_predictor.sv
src/branch_target_buffer.sv
src/fetch_decide.sv
src/fetch_unit.sv
bench/tb_clock_gen.sv
bench/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module fetch_unit_tb -f filelist.f -o fetch_unit_sim

# a fatal stop returns nonzero, the log decides the result
./obj_dir/fetch_unit_sim > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

if grep -q "^all tests passed$" sim.log; then
  echo "simulation PASSED"
  exit 0
else
  echo "simulation FAILED, see sim.log"
  exit 1
fi
